// File: project.f
rtl/lsq_pkg.sv
rtl/lsq_queue.sv
rtl/lsq_launch.sv
rtl/tagged_mem.sv
rtl/lsq_top.sv
sim/lsq_tb.sv

// File: rtl/lsq_launch.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_launch import lsq_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [LSQ_IDX-1:0] head,
	input  logic [LSQ_IDX:0]   count,
	input  lsq_entry_s         launch_entry,
	output logic [LSQ_IDX-1:0] launch_idx,
	input  logic [ROB_IDX-1:0] rob_head,
	input  logic               commit_ready,
	// memory side
	output mem_req_s           mem_req,
	input  logic [TAG_W-1:0]   mem_tag,
	input  logic               resp_valid,
	input  mem_resp_s          resp,
	// back to the queue
	output logic               fill_valid,
	output logic [LSQ_IDX-1:0] fill_idx,
	output logic [DATA_W-1:0]  fill_data,
	output logic               store_commit
);

	logic [LSQ_IDX-1:0] ptr;
	logic [LSQ_IDX-1:0] ptr_off;                  // distance from head
	logic [LSQ_IDX-1:0] tag_map [1:NUM_MEM_TAGS]; // tag -> queue index
	logic [NUM_MEM_TAGS:1] tag_busy;
	logic ptr_inflight, ptr_pending;
	logic load_go, store_go, load_acc, launch_fire;

	assign launch_idx = ptr;
	assign ptr_off    = ptr - head;

	// a full queue with everything launched puts ptr back on head,
	// so check whether the entry there has already gone out
	always_comb begin
		ptr_inflight = 1'b0;
		for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
			if (tag_busy[t] && (tag_map[t] == ptr))
				ptr_inflight = 1'b1;
		end
	end

	assign ptr_pending = ({1'b0, ptr_off} < count) && !launch_entry.data_ready && !ptr_inflight;

	// ============================================================
	// launch decision
	// ============================================================
	assign load_go  = ptr_pending && launch_entry.addr_ready && !launch_entry.op.is_store;
	assign store_go = ptr_pending && launch_entry.addr_ready && launch_entry.op.is_store &&
		(ptr == head) && (launch_entry.op.rob_idx == rob_head) && commit_ready;

	always_comb begin
		mem_req.addr = launch_entry.addr;
		mem_req.data = launch_entry.data;
		if (store_go)
			mem_req.cmd = BUS_STORE;
		else if (load_go)
			mem_req.cmd = BUS_LOAD;
		else
			mem_req.cmd = BUS_NONE;
	end

	assign load_acc     = load_go && (mem_tag != '0);  // refused loads retry
	assign launch_fire  = store_go || load_acc;
	assign store_commit = store_go;

	// responses go straight back as fills
	assign fill_valid = resp_valid;
	assign fill_idx   = tag_map[resp.tag];
	assign fill_data  = resp.data;

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr      <= '0;
			tag_busy <= '0;
		end else begin
			if (launch_fire)
				ptr <= ptr + 1'b1;
			if (resp_valid)
				tag_busy[resp.tag] <= 1'b0;
			if (load_acc)
				tag_busy[mem_tag] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_acc)
			tag_map[mem_tag] <= ptr;
	end

	a_resp_mapped: assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> (resp.tag != '0) && tag_busy[resp.tag]);

endmodule

`default_nettype wire

// File: rtl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

	// ============================================================
	// sizes
	// ============================================================
	localparam int LSQ_SZ       = 8;
	localparam int LSQ_IDX      = 3;   // queue index bits
	localparam int ROB_IDX      = 5;
	localparam int PRF_IDX      = 6;
	localparam int DATA_W       = 32;  // address and data
	localparam int NUM_MEM_TAGS = 3;   // tag 0 is the refusal code
	localparam int TAG_W        = 2;
	localparam int MEM_LATENCY  = 4;   // accept to response, in cycles
	localparam int MEM_WORDS    = 64;  // word index from addr[7:2]

	localparam logic [DATA_W-1:0] MEM_INIT_KEY = 32'h3c5a_e17d;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_LOAD  = 2'd1,
		BUS_STORE = 2'd2
	} bus_cmd_e;

	// ============================================================
	// payloads
	// ============================================================
	typedef struct packed {
		logic               is_store;
		logic [ROB_IDX-1:0] rob_idx;
		logic [PRF_IDX-1:0] pdest;   // only meaningful for loads
	} disp_s;

	typedef struct packed {
		logic [LSQ_IDX-1:0] lsq_idx;
		logic [DATA_W-1:0]  addr;
		logic [DATA_W-1:0]  data;    // store data, ignored for loads
	} upd_s;

	typedef struct packed {
		disp_s             op;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] data;       // store data, or load data after the fill
		logic              addr_ready;
		logic              data_ready; // load data has come back
	} lsq_entry_s;

	typedef struct packed {
		logic [ROB_IDX-1:0] rob_idx;
		logic [PRF_IDX-1:0] pdest;
		logic               is_store;
		logic [DATA_W-1:0]  value;
	} commit_s;

	typedef struct packed {
		bus_cmd_e          cmd;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_req_s;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] data;
	} mem_resp_s;

	// reset value of memory word n
	function automatic logic [DATA_W-1:0] mem_init_word(input int unsigned n);
		return DATA_W'(n) ^ MEM_INIT_KEY;
	endfunction

endpackage

`default_nettype wire

// File: rtl/lsq_queue.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_queue import lsq_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	// dispatch
	input  logic               disp_valid,
	input  disp_s              disp,
	output logic               disp_ready,
	output logic [LSQ_IDX-1:0] alloc_idx,
	// execute update
	input  logic               upd_valid,
	input  upd_s               upd,
	// launch read port
	input  logic [LSQ_IDX-1:0] launch_idx,
	output lsq_entry_s         launch_entry,
	output logic [LSQ_IDX-1:0] head,
	output logic [LSQ_IDX:0]   count,
	// returns from the launch stage
	input  logic               fill_valid,
	input  logic [LSQ_IDX-1:0] fill_idx,
	input  logic [DATA_W-1:0]  fill_data,
	input  logic               store_commit,
	// commit
	output logic               commit_valid,
	output commit_s            commit,
	input  logic               commit_ready
);

	lsq_entry_s entries [LSQ_SZ];

	logic [LSQ_IDX-1:0] tail;
	logic [LSQ_IDX-1:0] next_head, next_tail;
	logic [LSQ_IDX:0]   next_count;
	logic               disp_fire, commit_fire;
	lsq_entry_s         head_entry;
	logic [LSQ_IDX-1:0] upd_off;

	assign disp_ready   = (count != (LSQ_IDX+1)'(LSQ_SZ));
	assign alloc_idx    = tail;
	assign disp_fire    = disp_valid && disp_ready;
	assign launch_entry = entries[launch_idx];
	assign head_entry   = entries[head];

	// stores commit together with their launch, loads once filled
	assign commit_valid = (count != '0) &&
		(head_entry.op.is_store ? store_commit : head_entry.data_ready);
	assign commit_fire  = commit_valid && commit_ready;

	always_comb begin
		commit.rob_idx  = head_entry.op.rob_idx;
		commit.pdest    = head_entry.op.pdest;
		commit.is_store = head_entry.op.is_store;
		commit.value    = head_entry.data;
	end

	// ============================================================
	// next state for head, tail and occupancy
	// ============================================================
	always_comb begin
		next_head  = head;
		next_tail  = tail;
		next_count = count;

		if (commit_fire)
			next_head = head + 1'b1;
		if (disp_fire)
			next_tail = tail + 1'b1;

		case ({disp_fire, commit_fire})
			2'b10:   next_count = count + 1'b1;
			2'b01:   next_count = count - 1'b1;
			default: next_count = count;  // none, or one in and one out
		endcase
	end

	// ============================================================
	// sequential
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= next_head;
			tail  <= next_tail;
			count <= next_count;
		end
	end

	// entry contents; the three write sources never share an index
	always_ff @(posedge clk) begin
		if (disp_fire) begin
			entries[tail].op         <= disp;
			entries[tail].addr_ready <= 1'b0;
			entries[tail].data_ready <= 1'b0;
		end
		if (upd_valid) begin
			entries[upd.lsq_idx].addr       <= upd.addr;
			entries[upd.lsq_idx].data       <= upd.data;
			entries[upd.lsq_idx].addr_ready <= 1'b1;
		end
		if (fill_valid) begin
			entries[fill_idx].data       <= fill_data;  // load result
			entries[fill_idx].data_ready <= 1'b1;
		end
	end

	// update must name an occupied entry that has no address yet
	assign upd_off = upd.lsq_idx - head;

	a_upd_in_range: assert property (@(posedge clk) disable iff (reset)
		upd_valid |-> ({1'b0, upd_off} < count) && !entries[upd.lsq_idx].addr_ready);

	// dispatch only writes the free slot count entries past the head
	a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
		disp_fire |-> ((tail - head) == count[LSQ_IDX-1:0]) && (count < LSQ_SZ));

endmodule

`default_nettype wire

// File: rtl/lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_top import lsq_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               disp_valid,
	input  disp_s              disp,
	output logic               disp_ready,
	output logic [LSQ_IDX-1:0] alloc_idx,
	input  logic               upd_valid,
	input  upd_s               upd,
	input  logic [ROB_IDX-1:0] rob_head,
	output logic               commit_valid,
	output commit_s            commit,
	input  logic               commit_ready
);

	logic [LSQ_IDX-1:0] launch_idx, head, fill_idx;
	logic [LSQ_IDX:0]   count;
	lsq_entry_s         launch_entry;
	logic               fill_valid, store_commit, resp_valid;
	logic [DATA_W-1:0]  fill_data;
	mem_req_s           mem_req;
	logic [TAG_W-1:0]   mem_tag;
	mem_resp_s          resp;

	lsq_queue i_lsq_queue (
		.clk, .reset,
		.disp_valid, .disp, .disp_ready, .alloc_idx,
		.upd_valid, .upd,
		.launch_idx, .launch_entry, .head, .count,
		.fill_valid, .fill_idx, .fill_data, .store_commit,
		.commit_valid, .commit, .commit_ready
	);

	lsq_launch i_lsq_launch (
		.clk, .reset,
		.head, .count, .launch_entry, .launch_idx,
		.rob_head, .commit_ready,
		.mem_req, .mem_tag, .resp_valid, .resp,
		.fill_valid, .fill_idx, .fill_data, .store_commit
	);

	tagged_mem i_tagged_mem (
		.clk, .reset,
		.mem_req, .mem_tag, .resp_valid, .resp
	);

endmodule

`default_nettype wire

// File: rtl/tagged_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tagged_mem import lsq_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  mem_req_s         mem_req,
	output logic [TAG_W-1:0] mem_tag,
	output logic             resp_valid,
	output mem_resp_s        resp
);

	localparam int WORD_W = $clog2(MEM_WORDS);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic [NUM_MEM_TAGS:1]  busy;
	logic [TAG_W-1:0]       free_tag;   // lowest free, 0 if none
	logic [WORD_W-1:0]      word;
	logic                   load_acc;
	logic [MEM_LATENCY-1:0] pipe_valid;
	mem_resp_s              pipe [MEM_LATENCY];

	assign word = mem_req.addr[2 +: WORD_W];

	always_comb begin
		free_tag = '0;
		for (int t = NUM_MEM_TAGS; t >= 1; t--) begin
			if (!busy[t])
				free_tag = TAG_W'(t);
		end
	end

	assign load_acc = (mem_req.cmd == BUS_LOAD) && (free_tag != '0);
	assign mem_tag  = (mem_req.cmd == BUS_LOAD) ? free_tag : '0;

	assign resp_valid = pipe_valid[MEM_LATENCY-1];
	assign resp       = pipe[MEM_LATENCY-1];

	// ============================================================
	// storage, tag pool and delay line control
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= '0;
			pipe_valid <= '0;
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= mem_init_word(i);
		end else begin
			pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], load_acc};
			if (resp_valid)
				busy[resp.tag] <= 1'b0;  // freed as the response leaves
			if (load_acc)
				busy[free_tag] <= 1'b1;
			if (mem_req.cmd == BUS_STORE)
				mem[word] <= mem_req.data;
		end
	end

	// load data is sampled at acceptance
	always_ff @(posedge clk) begin
		pipe[0].tag  <= free_tag;
		pipe[0].data <= mem[word];
		for (int i = 1; i < MEM_LATENCY; i++)
			pipe[i] <= pipe[i-1];
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the LSQ testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module lsq_tb -o lsq_sim \
	&& ./obj_dir/lsq_sim \
	|| { echo "simulation did not pass"; exit 1; }

// File: sim/lsq_golden.txt
// kind (0 load, 1 store), rob index, dest reg, address, store data, expected commit value
// loads expect word index xor 3c5ae17d, or the latest earlier store to that word
0 1c 05 00000010 00000000 3c5ae179
0 1d 06 00000024 00000000 3c5ae174
0 1e 07 000000fc 00000000 3c5ae142
1 1f 00 00000010 deadbeef deadbeef
0 00 08 00000010 00000000 deadbeef
0 01 09 00000080 00000000 3c5ae15d
1 02 00 00000024 12345678 12345678
1 03 00 00000024 0badf00d 0badf00d
0 04 0a 00000024 00000000 0badf00d
0 05 0b 00000004 00000000 3c5ae17c
0 06 0c 00000000 00000000 3c5ae17d
0 07 0d 000000a8 00000000 3c5ae157
1 08 00 000000a8 cafef00d cafef00d
0 09 0e 000000a8 00000000 cafef00d
0 0a 0f 00000010 00000000 deadbeef
0 0b 10 000000fc 00000000 3c5ae142

// File: sim/lsq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

	localparam int N_OPS    = 16;
	localparam int COLS     = 6;            // words per golden line
	localparam int WATCHDOG = N_OPS * 40;   // cycles

	typedef struct packed {
		disp_s             op;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] result;  // expected commit value
	} op_rec_s;

	logic               clk = 1'b0;
	logic               reset;
	logic               disp_valid;
	disp_s              disp;
	logic               disp_ready;
	logic [LSQ_IDX-1:0] alloc_idx;
	logic               upd_valid;
	upd_s               upd;
	logic [ROB_IDX-1:0] rob_head;
	logic               commit_valid;
	commit_s            commit;
	logic               commit_ready;

	logic [DATA_W-1:0]  gold [N_OPS*COLS];
	op_rec_s            ops [N_OPS];
	int                 seed;
	int                 disp_n, com_n, cycle;
	int                 pend_op [$];
	int                 pend_due [$];  // last cycle before the update may go out
	logic [LSQ_IDX-1:0] pend_idx [$];
	logic               hold_chk;
	commit_s            held;

	always #4 clk = ~clk;

	lsq_top i_lsq_top (
		.clk, .reset,
		.disp_valid, .disp, .disp_ready, .alloc_idx,
		.upd_valid, .upd, .rob_head,
		.commit_valid, .commit, .commit_ready
	);

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("tests failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic load_golden();
		$readmemh("sim/lsq_golden.txt", gold);
		for (int i = 0; i < N_OPS; i++) begin
			ops[i].op.is_store = gold[COLS*i][0];
			ops[i].op.rob_idx  = gold[COLS*i+1][ROB_IDX-1:0];
			ops[i].op.pdest    = gold[COLS*i+2][PRF_IDX-1:0];
			ops[i].addr        = gold[COLS*i+3];
			ops[i].data        = gold[COLS*i+4];
			ops[i].result      = gold[COLS*i+5];
		end
	endtask

	// ============================================================
	// stimulus for the next edge
	// ============================================================
	task automatic drive_inputs();
		int k;
		disp_valid <= (disp_n < N_OPS);
		if (disp_n < N_OPS)
			disp <= ops[disp_n].op;
		if (com_n < N_OPS) begin
			if (($random(seed) & 7) == 0)
				rob_head <= ops[com_n].op.rob_idx - 1'b1;  // older non-memory op still ahead
			else
				rob_head <= ops[com_n].op.rob_idx;  // oldest uncommitted op
		end
		upd_valid <= 1'b0;
		if (pend_op.size() != 0 && pend_due[0] < cycle) begin
			k = pend_op.pop_front();
			void'(pend_due.pop_front());
			upd_valid   <= 1'b1;
			upd.lsq_idx <= pend_idx.pop_front();
			upd.addr    <= ops[k].addr;
			upd.data    <= ops[k].data;
		end
		commit_ready <= (($random(seed) & 3) != 0);  // low about one cycle in four
	endtask

	// ============================================================
	// checks on the values that the edge captures
	// ============================================================
	task automatic sample_outputs();
		check_eq("disp_ready", disp_ready, (disp_n - com_n) != LSQ_SZ);
		if (hold_chk) begin
			check_eq("commit_valid", commit_valid, 1'b1);
			check_eq("commit", commit, held);
		end
		hold_chk = commit_valid && !commit_ready;
		held     = commit;

		if (disp_valid && disp_ready) begin
			check_eq("alloc_idx", alloc_idx, disp_n % LSQ_SZ);
			pend_idx.push_back(alloc_idx);
			pend_op.push_back(disp_n);
			pend_due.push_back(cycle + int'($unsigned($random(seed)) % 4));  // 0 to 3 cycles
			disp_n++;
		end

		if (commit_valid && commit_ready) begin
			check_eq("commit.rob_idx", commit.rob_idx, ops[com_n].op.rob_idx);
			check_eq("commit.pdest", commit.pdest, ops[com_n].op.pdest);
			check_eq("commit.is_store", commit.is_store, ops[com_n].op.is_store);
			check_eq("commit.value", commit.value, ops[com_n].result);
			if (commit.is_store)
				check_eq("rob_head", rob_head, commit.rob_idx);
			com_n++;
		end
		cycle++;
	endtask

	initial begin
		seed = 32'hb67e_4993;
		load_golden();
		reset        = 1'b1;
		disp_valid   = 1'b0;
		disp         = '0;
		upd_valid    = 1'b0;
		upd          = '0;
		rob_head     = ops[0].op.rob_idx;
		commit_ready = 1'b0;
		disp_n       = 0;
		com_n        = 0;
		cycle        = 0;
		hold_chk     = 1'b0;
		held         = '0;

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_eq("disp_ready", disp_ready, 1'b1);
		check_eq("commit_valid", commit_valid, 1'b0);
		check_eq("alloc_idx", alloc_idx, 0);

		while (com_n < N_OPS) begin
			drive_inputs();
			@(posedge clk);
			sample_outputs();
		end
		$display("all tests passed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("timeout: %0d of %0d ops committed after %0d cycles", com_n, N_OPS, WATCHDOG);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
